// File: include/merge_cfg_cfg.svh
// widths, depths and thresholds of the merge configuration engine, included by RTL and testbench
`ifndef MERGE_CFG_CFG_SVH
`define MERGE_CFG_CFG_SVH

// --------------------------------------------------
// response word fields
// --------------------------------------------------
`define MCFG_OFFSET_W 32
`define MCFG_SHIFT_W 5
`define MCFG_DATA_W 32

// merge mask and merge type, one bit or code per field
`define MCFG_FIELDS 8

// --------------------------------------------------
// engine window
// --------------------------------------------------
`define MCFG_SEQ_SLOTS 16
`define MCFG_SLOT_W 4

// --------------------------------------------------
// FIFO sizing
// --------------------------------------------------
`define MCFG_FIFO_DEPTH 16
`define MCFG_PROG_THRESH 8

`endif

// File: rtl/merge_cfg_pkg.sv
// shared types of the merge configuration engine, referenced by scoped names from RTL and testbench
`include "merge_cfg_cfg.svh"

package merge_cfg_pkg;

    // buffer class carried by each response word
    typedef enum logic [1:0] {
        class_invalid      = 2'd0,
        class_cu_setup     = 2'd1,
        class_engine_setup = 2'd2,
        class_other        = 2'd3
    } buffer_class_e;

    // one entry of the response FIFO
    typedef struct packed {
        logic [`MCFG_SLOT_W-1:0] slot;
        logic [`MCFG_DATA_W-1:0] data;
    } resp_entry_t;

    // slot 0 carries the mask, slot 1 the type code, same bit positions
    typedef union packed {
        struct packed {
            logic [`MCFG_DATA_W-`MCFG_FIELDS-1:0] rsvd;
            logic [`MCFG_FIELDS-1:0]              merge_mask;
        } as_mask;
        struct packed {
            logic [`MCFG_DATA_W-`MCFG_FIELDS-1:0] rsvd;
            logic [`MCFG_FIELDS-1:0]              merge_type;
        } as_type;
    } setup_word_u;

    // one finished engine configuration
    typedef struct packed {
        logic [`MCFG_FIELDS-1:0] merge_mask;
        logic [`MCFG_FIELDS-1:0] merge_type;
    } merge_config_t;

endpackage

// File: rtl/fifo_if.sv
// write, read and status signals of one synchronous FIFO, shared by its writer, reader and storage
`timescale 1ns/100ps

interface fifo_if #(
    parameter int width = 32
);

    // --------------------------------------------------
    // write side
    // --------------------------------------------------
    logic             wr_en;
    logic [width-1:0] din;
    logic             full;
    logic             prog_full;

    // --------------------------------------------------
    // read side
    // --------------------------------------------------
    logic             rd_en;
    logic [width-1:0] dout;
    logic             valid;
    logic             empty;

    modport writer (
        output wr_en, din,
        input  full, prog_full
    );

    // reader also sees prog_full for its own throttling
    modport reader (
        output rd_en,
        input  dout, valid, empty, prog_full
    );

    modport fifo (
        input  wr_en, din, rd_en,
        output full, prog_full, dout, valid, empty
    );

endinterface

// File: rtl/sync_fifo.sv
// single-clock FIFO with read valid and programmable full, instantiated for responses and configurations
`timescale 1ns/100ps
`include "merge_cfg_cfg.svh"

module sync_fifo #(
    parameter int width = 36
) (
    input logic   ap_clk,
    input logic   rst_n,
    fifo_if.fifo  port
);

    localparam int depth = `MCFG_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    // writes into a full FIFO are lost
    assign push = port.wr_en & ~port.full;
    assign pop  = port.rd_en & ~port.empty;

    assign port.full      = (count == depth);
    assign port.empty     = (count == '0);
    assign port.prog_full = (count >= `MCFG_PROG_THRESH);

    // --------------------------------------------------
    // pointers and fill level
    // --------------------------------------------------
    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            port.valid <= 1'b0;
        end else begin
            port.valid <= pop;
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------------------------------------
    // storage and read data
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= port.din;
        end
        // dout holds the popped entry while valid is high
        if (pop) begin
            port.dout <= mem[rd_ptr];
        end
    end

endmodule

// File: rtl/setup_filter.sv
// registers incoming response words and pushes setup words of this engine's window to the response FIFO
`timescale 1ns/100ps
`include "merge_cfg_cfg.svh"

module setup_filter #(
    parameter int id_relative = 0
) (
    input  logic                        ap_clk,
    input  logic                        rst_n,
    input  logic                        resp_valid,
    input  merge_cfg_pkg::buffer_class_e resp_class,
    input  logic [`MCFG_OFFSET_W-1:0]   resp_offset,
    input  logic [`MCFG_SHIFT_W-1:0]    resp_shift,
    input  logic [`MCFG_DATA_W-1:0]     resp_data,
    fifo_if.writer                      resp_wr
);

    // window of slots owned by this engine
    localparam int seq_start = id_relative * `MCFG_SEQ_SLOTS;
    localparam logic [`MCFG_OFFSET_W-1:0] win_lo = seq_start;
    localparam logic [`MCFG_OFFSET_W-1:0] win_hi = seq_start + `MCFG_SEQ_SLOTS;

    logic                         valid_q;
    merge_cfg_pkg::buffer_class_e class_q;
    logic [`MCFG_OFFSET_W-1:0]    offset_q;
    logic [`MCFG_SHIFT_W-1:0]     shift_q;
    logic [`MCFG_DATA_W-1:0]      data_q;
    logic [`MCFG_OFFSET_W-1:0]    seq;
    logic [`MCFG_OFFSET_W-1:0]    seq_rel;
    logic                         class_ok;
    logic                         in_window;
    merge_cfg_pkg::resp_entry_t   entry;

    // --------------------------------------------------
    // input register
    // --------------------------------------------------
    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= resp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        class_q  <= resp_class;
        offset_q <= resp_offset;
        shift_q  <= resp_shift;
        data_q   <= resp_data;
    end

    // --------------------------------------------------
    // sequence decode and filter
    // --------------------------------------------------
    assign seq       = offset_q >> shift_q;
    assign seq_rel   = seq - win_lo;
    assign in_window = (seq >= win_lo) && (seq < win_hi);
    assign class_ok  = (class_q == merge_cfg_pkg::class_cu_setup) ||
                       (class_q == merge_cfg_pkg::class_engine_setup);

    assign entry.slot = seq_rel[`MCFG_SLOT_W-1:0];
    assign entry.data = data_q;

    assign resp_wr.wr_en = valid_q & class_ok & in_window;
    assign resp_wr.din   = entry;

endmodule

// File: rtl/config_collector.sv
// pops setup words, tracks the 16-slot run and writes one merge configuration per completed run
`timescale 1ns/100ps
`include "merge_cfg_cfg.svh"

module config_collector (
    input logic     ap_clk,
    input logic     rst_n,
    input logic     resp_rd_en,
    fifo_if.reader  resp_rd,
    fifo_if.writer  cfg_wr
);

    localparam int slots = `MCFG_SEQ_SLOTS;

    merge_cfg_pkg::resp_entry_t   entry;
    merge_cfg_pkg::setup_word_u   word;
    merge_cfg_pkg::merge_config_t cfg_q;
    logic [slots-1:0]             run_q;
    logic                         emit;
    logic                         start;

    assign entry = resp_rd.dout;
    assign word  = entry.data;

    // top bit of the run means all slots have been seen
    assign emit = run_q[slots-1];

    // a slot-0 word may also start a new run in the emit cycle
    assign start = resp_rd.valid & (entry.slot == '0) & ((run_q == '0) | emit);

    // --------------------------------------------------
    // pop request
    // --------------------------------------------------
    assign resp_rd.rd_en = ~resp_rd.empty & resp_rd_en & ~emit & ~cfg_wr.prog_full;

    // --------------------------------------------------
    // one-hot run register
    // --------------------------------------------------
    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= '0;
        end else if (start) begin
            run_q <= {{(slots - 1){1'b0}}, 1'b1};
        end else if (resp_rd.valid) begin
            // idle words with a non-zero slot shift zero and stay idle
            run_q <= run_q << 1;
        end else if (emit) begin
            run_q <= '0;
        end
    end

    // --------------------------------------------------
    // mask and type capture
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (start) begin
            cfg_q.merge_mask <= word.as_mask.merge_mask;
        end else if (resp_rd.valid && run_q[0]) begin
            // word right after slot 0 holds the type code
            cfg_q.merge_type <= word.as_type.merge_type;
        end
    end

    // configuration FIFO samples cfg_q before any new slot-0 capture
    assign cfg_wr.wr_en = emit;
    assign cfg_wr.din   = cfg_q;

endmodule

// File: rtl/merge_cfg_top.sv
// top level of the merge configuration engine, plain ports toward the overlay and its testbench
`timescale 1ns/100ps
`include "merge_cfg_cfg.svh"

module merge_cfg_top #(
    parameter int id_relative = 0
) (
    input  logic                         ap_clk,
    input  logic                         rst_n,
    input  logic                         resp_valid,
    input  merge_cfg_pkg::buffer_class_e resp_class,
    input  logic [`MCFG_OFFSET_W-1:0]    resp_offset,
    input  logic [`MCFG_SHIFT_W-1:0]     resp_shift,
    input  logic [`MCFG_DATA_W-1:0]      resp_data,
    input  logic                         resp_rd_en,
    output logic                         resp_empty,
    input  logic                         cfg_rd_en,
    output logic                         cfg_valid,
    output logic [`MCFG_FIELDS-1:0]      cfg_merge_mask,
    output logic [`MCFG_FIELDS-1:0]      cfg_merge_type,
    output logic                         cfg_empty
);

    localparam int resp_w = $bits(merge_cfg_pkg::resp_entry_t);
    localparam int cfg_w  = $bits(merge_cfg_pkg::merge_config_t);

    merge_cfg_pkg::merge_config_t cfg_out;

    fifo_if #(.width(resp_w)) resp_if ();
    fifo_if #(.width(cfg_w))  cfg_if ();

    // --------------------------------------------------
    // response path
    // --------------------------------------------------
    setup_filter #(.id_relative(id_relative)) setup_filter_i (
        .ap_clk      (ap_clk),
        .rst_n       (rst_n),
        .resp_valid  (resp_valid),
        .resp_class  (resp_class),
        .resp_offset (resp_offset),
        .resp_shift  (resp_shift),
        .resp_data   (resp_data),
        .resp_wr     (resp_if.writer)
    );

    sync_fifo #(.width(resp_w)) resp_fifo_i (
        .ap_clk (ap_clk),
        .rst_n  (rst_n),
        .port   (resp_if.fifo)
    );

    config_collector config_collector_i (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .resp_rd_en (resp_rd_en),
        .resp_rd    (resp_if.reader),
        .cfg_wr     (cfg_if.writer)
    );

    // --------------------------------------------------
    // configuration path
    // --------------------------------------------------
    sync_fifo #(.width(cfg_w)) cfg_fifo_i (
        .ap_clk (ap_clk),
        .rst_n  (rst_n),
        .port   (cfg_if.fifo)
    );

    // reader side of the configuration FIFO goes straight to the ports
    assign cfg_if.rd_en   = cfg_rd_en;
    assign cfg_out        = cfg_if.dout;
    assign cfg_valid      = cfg_if.valid;
    assign cfg_merge_mask = cfg_out.merge_mask;
    assign cfg_merge_type = cfg_out.merge_type;
    assign cfg_empty      = cfg_if.empty;
    assign resp_empty     = resp_if.empty;

endmodule

// File: testbench/tb_clock_gen.sv
// free-running ap_clk for the testbench, 100 ns period
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter realtime period = 100.0
) (
    output logic ap_clk
);

    initial begin
        ap_clk = 1'b0;
        forever begin
            #(period / 2) ap_clk = ~ap_clk;
        end
    end

endmodule

// File: testbench/merge_cfg_sva.sv
// run and pop checks on the config collector, attached with bind from the testbench top
`timescale 1ns/100ps
`include "merge_cfg_cfg.svh"

module merge_cfg_sva (
    input logic                       ap_clk,
    input logic                       rst_n,
    input logic                       emit,
    input logic [`MCFG_SEQ_SLOTS-1:0] run_q,
    input logic                       pop_req,
    input logic                       resp_empty,
    input logic                       pop_valid
);

    // count of failed assertions
    int failures = 0;

    // emit drops right after the configuration write
    emit_one_cycle: assert property (
        @(posedge ap_clk) disable iff (!rst_n) emit |=> !emit
    ) else begin
        $error("emit pulse lasted more than one cycle");
        failures++;
    end

    // idle or exactly one slot position
    run_onehot: assert property (
        @(posedge ap_clk) disable iff (!rst_n) $onehot0(run_q)
    ) else begin
        $error("run register holds more than one set bit");
        failures++;
    end

    // every word handed to the collector left a non-empty FIFO
    no_pop_when_empty: assert property (
        @(posedge ap_clk) disable iff (!rst_n) pop_valid |-> $past(pop_req && !resp_empty)
    ) else begin
        $error("word delivered without a pop from a non-empty response FIFO");
        failures++;
    end

endmodule

// File: testbench/merge_cfg_tb.sv
// directed testbench of the merge configuration engine, compiled with compile.f from the project root
`timescale 1ns/100ps
`include "merge_cfg_cfg.svh"

module merge_cfg_tb;

    // engine 1 owns sequence numbers 16 to 31
    localparam int win_start  = 1 * `MCFG_SEQ_SLOTS;
    localparam int wait_limit = 200;

    logic                         ap_clk;
    logic                         rst_n;
    logic                         resp_valid;
    merge_cfg_pkg::buffer_class_e resp_class;
    logic [`MCFG_OFFSET_W-1:0]    resp_offset;
    logic [`MCFG_SHIFT_W-1:0]     resp_shift;
    logic [`MCFG_DATA_W-1:0]      resp_data;
    logic                         resp_rd_en;
    logic                         resp_empty;
    logic                         cfg_rd_en;
    logic                         cfg_valid;
    logic [`MCFG_FIELDS-1:0]      cfg_merge_mask;
    logic [`MCFG_FIELDS-1:0]      cfg_merge_type;
    logic                         cfg_empty;

    integer seed   = 26395;
    int     tests  = 0;
    int     checks = 0;
    int     errors = 0;

    tb_clock_gen clock_gen_i (.ap_clk(ap_clk));

    merge_cfg_top #(.id_relative(1)) merge_cfg_top_i (.*);

    bind config_collector merge_cfg_sva collector_sva_i (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .emit       (emit),
        .run_q      (run_q),
        .pop_req    (resp_rd.rd_en),
        .resp_empty (resp_rd.empty),
        .pop_valid  (resp_rd.valid)
    );

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    // drive and sample point, 10 ns after the rising edge
    task automatic step();
        @(posedge ap_clk);
        #10;
    endtask

    task automatic expect_equal(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic offer_word(input merge_cfg_pkg::buffer_class_e cls, input int seq,
                              input int shift, input logic [31:0] data);
        resp_valid  = 1'b1;
        resp_class  = cls;
        resp_offset = seq << shift;
        resp_shift  = `MCFG_SHIFT_W'(shift);
        resp_data   = data;
        step();
        resp_valid = 1'b0;
    endtask

    // slots 0 to 15 back to back, both setup classes used
    task automatic offer_run(input int shift, output logic [7:0] mask, output logic [7:0] kind);
        logic [31:0]                  data;
        merge_cfg_pkg::buffer_class_e cls;
        for (int s = 0; s < `MCFG_SEQ_SLOTS; s++) begin
            data = $random(seed);
            if (s == 0) begin
                mask = data[7:0];
            end
            if (s == 1) begin
                kind = data[7:0];
            end
            if (s % 2) begin
                cls = merge_cfg_pkg::class_cu_setup;
            end else begin
                cls = merge_cfg_pkg::class_engine_setup;
            end
            offer_word(cls, win_start + s, shift, data);
        end
    endtask

    task automatic wait_resp_drain();
        int n = 0;
        while (!resp_empty && n < wait_limit) begin
            step();
            n++;
        end
        assert (resp_empty) else begin
            $display("timed out at %0d ns waiting for the response FIFO to drain", $time);
            errors++;
        end
        // pop, valid, emit and configuration write
        repeat (4) step();
    endtask

    task automatic read_config(input logic [7:0] mask, input logic [7:0] kind);
        int n = 0;
        while (cfg_empty && n < wait_limit) begin
            step();
            n++;
        end
        assert (!cfg_empty) else begin
            $display("timed out at %0d ns waiting for a configuration", $time);
            errors++;
        end
        cfg_rd_en = 1'b1;
        step();
        cfg_rd_en = 1'b0;
        expect_equal("cfg_valid after read", cfg_valid, 1);
        expect_equal("cfg_merge_mask", cfg_merge_mask, mask);
        expect_equal("cfg_merge_type", cfg_merge_type, kind);
        step();
        expect_equal("cfg_valid one cycle later", cfg_valid, 0);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("test %-14s %0d errors", name, errors - errors_before);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_filter_reject();
        int e = errors;
        resp_rd_en = 1'b0;
        offer_word(merge_cfg_pkg::class_other, win_start, 0, 32'h1111_1111);
        offer_word(merge_cfg_pkg::class_invalid, win_start + 1, 0, 32'h2222_2222);
        offer_word(merge_cfg_pkg::class_cu_setup, win_start - 1, 0, 32'h3333_3333);
        offer_word(merge_cfg_pkg::class_engine_setup, win_start + 16, 0, 32'h4444_4444);
        repeat (4) begin
            step();
            expect_equal("resp_empty", resp_empty, 1);
        end
        finish_test("filter_reject", e);
    endtask

    // lead words 5 to 7 arrive while idle and must be ignored
    task automatic test_full_run(input string name, input int shift, input bit lead);
        int         e = errors;
        logic [7:0] mask;
        logic [7:0] kind;
        resp_rd_en = 1'b1;
        if (lead) begin
            for (int s = 5; s <= 7; s++) begin
                offer_word(merge_cfg_pkg::class_engine_setup, win_start + s, shift,
                           $random(seed));
            end
        end
        offer_run(shift, mask, kind);
        read_config(mask, kind);
        wait_resp_drain();
        expect_equal("cfg_empty after one run", cfg_empty, 1);
        finish_test(name, e);
    endtask

    task automatic test_backpressure();
        int         e = errors;
        logic [7:0] mask [3];
        logic [7:0] kind [3];
        resp_rd_en = 1'b0;
        offer_run(0, mask[0], kind[0]);
        repeat (10) begin
            step();
            expect_equal("resp_empty while held", resp_empty, 0);
        end
        resp_rd_en = 1'b1;
        wait_resp_drain();
        offer_run(0, mask[1], kind[1]);
        offer_run(0, mask[2], kind[2]);
        wait_resp_drain();
        for (int r = 0; r < 3; r++) begin
            read_config(mask[r], kind[r]);
        end
        expect_equal("cfg_empty after three reads", cfg_empty, 1);
        finish_test("backpressure", e);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        rst_n       = 1'b0;
        resp_valid  = 1'b0;
        resp_class  = merge_cfg_pkg::class_invalid;
        resp_offset = '0;
        resp_shift  = '0;
        resp_data   = '0;
        resp_rd_en  = 1'b0;
        cfg_rd_en   = 1'b0;
        repeat (8) @(posedge ap_clk);
        #10;
        rst_n = 1'b1;
        expect_equal("resp_empty after reset", resp_empty, 1);
        expect_equal("cfg_empty after reset", cfg_empty, 1);
        expect_equal("cfg_valid after reset", cfg_valid, 0);

        test_filter_reject();
        test_full_run("full_run", 0, 1'b0);
        test_full_run("shift_decode", 2, 1'b0);
        test_full_run("idle_start", 0, 1'b1);
        test_backpressure();

        // bound assertion failures count against the run
        errors += merge_cfg_top_i.config_collector_i.collector_sva_i.failures;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // hard limit on the whole run
    initial begin
        #1_000_000;
        $display("run stopped after 1 ms without reaching the end of the tests");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
rtl/merge_cfg_pkg.sv
rtl/fifo_if.sv
rtl/sync_fifo.sv
rtl/setup_filter.sv
rtl/config_collector.sv
rtl/merge_cfg_top.sv
testbench/tb_clock_gen.sv
testbench/merge_cfg_sva.sv
testbench/merge_cfg_tb.sv

// File: Bender.yml
package:
  name: merge_cfg

export_include_dirs:
  - include

sources:
  - rtl/merge_cfg_pkg.sv
  - rtl/fifo_if.sv
  - rtl/sync_fifo.sv
  - rtl/setup_filter.sv
  - rtl/config_collector.sv
  - rtl/merge_cfg_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/merge_cfg_sva.sv
      - testbench/merge_cfg_tb.sv
